// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths. Addresses count words.
`define SOC_ADDR_W 12
`define SOC_DATA_W 32

// Address bits above this one select the region.
`define SOC_REGION_LSB 10

`define SOC_SRAM_DEPTH   256
`define SOC_SENSOR_DEPTH 16

`endif

// ==== soc_pkg.sv ====
`include "soc_config.svh"

package soc_pkg;

    typedef logic [`SOC_ADDR_W-1:0]     addr_t;
    typedef logic [`SOC_DATA_W-1:0]     data_t;
    typedef logic [`SOC_REGION_LSB-1:0] off_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  we;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        REG_SRAM   = 2'd0,
        REG_SENSOR = 2'd1,
        REG_DMA    = 2'd2,
        REG_NONE   = 2'd3
    } region_e;

    typedef enum logic {
        XB_IDLE,
        XB_WAIT_RSP
    } xbar_state_e;

    typedef enum logic [2:0] {
        DMA_IDLE,
        RD_REQ,
        RD_WAIT,
        WR_REQ,
        WR_WAIT
    } dma_state_e;

endpackage

// ==== bus_xbar.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module bus_xbar (
    input  logic              clk,
    input  logic              rst,
    input  logic              m_req_valid_i [2],
    input  soc_pkg::bus_req_t m_req_i       [2],
    output logic              m_req_ready_o [2],
    output logic              m_rsp_valid_o [2],
    output soc_pkg::bus_rsp_t m_rsp_o       [2],
    output logic              s_req_valid_o [3],
    output soc_pkg::bus_req_t s_req_o       [3],
    input  logic              s_rsp_valid_i [3],
    input  soc_pkg::bus_rsp_t s_rsp_i       [3]
);

    soc_pkg::xbar_state_e state_q;
    soc_pkg::region_e     region_q;
    soc_pkg::region_e     region_c;
    logic                 rr_ptr_q;
    logic                 gnt_q;
    logic                 gnt_c;
    logic                 req_any;
    logic                 accept;
    soc_pkg::bus_req_t    req_c;
    logic                 rsp_valid;
    soc_pkg::bus_rsp_t    rsp;

    assign req_any = m_req_valid_i[0] | m_req_valid_i[1];

    // The pointer names the master that wins a tie.
    always_comb begin
        if (m_req_valid_i[0] && m_req_valid_i[1]) begin
            gnt_c = rr_ptr_q;
        end else begin
            gnt_c = m_req_valid_i[1];
        end
    end

    assign accept   = (state_q == soc_pkg::XB_IDLE) && req_any;
    assign req_c    = m_req_i[gnt_c];
    assign region_c = soc_pkg::region_e'(req_c.addr[`SOC_ADDR_W-1:`SOC_REGION_LSB]);

    assign m_req_ready_o[0] = accept && !gnt_c;
    assign m_req_ready_o[1] = accept && gnt_c;

    assign s_req_valid_o[0] = accept && (region_c == soc_pkg::REG_SRAM);
    assign s_req_valid_o[1] = accept && (region_c == soc_pkg::REG_SENSOR);
    assign s_req_valid_o[2] = accept && (region_c == soc_pkg::REG_DMA);
    assign s_req_o[0] = req_c;
    assign s_req_o[1] = req_c;
    assign s_req_o[2] = req_c;

    // Unmapped accesses are answered here one cycle after acceptance.
    always_comb begin
        rsp_valid = 1'b0;
        rsp       = '0;
        if (state_q == soc_pkg::XB_WAIT_RSP) begin
            case (region_q)
                soc_pkg::REG_SRAM: begin
                    rsp_valid = s_rsp_valid_i[0];
                    rsp       = s_rsp_i[0];
                end
                soc_pkg::REG_SENSOR: begin
                    rsp_valid = s_rsp_valid_i[1];
                    rsp       = s_rsp_i[1];
                end
                soc_pkg::REG_DMA: begin
                    rsp_valid = s_rsp_valid_i[2];
                    rsp       = s_rsp_i[2];
                end
                default: begin
                    rsp_valid = 1'b1;
                    rsp.err   = 1'b1;
                end
            endcase
        end
    end

    assign m_rsp_valid_o[0] = rsp_valid && !gnt_q;
    assign m_rsp_valid_o[1] = rsp_valid && gnt_q;
    assign m_rsp_o[0] = rsp;
    assign m_rsp_o[1] = rsp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= soc_pkg::XB_IDLE;
            region_q <= soc_pkg::REG_SRAM;
            rr_ptr_q <= 1'b0;
            gnt_q    <= 1'b0;
        end else begin
            case (state_q)
                soc_pkg::XB_IDLE: begin
                    if (accept) begin
                        state_q  <= soc_pkg::XB_WAIT_RSP;
                        region_q <= region_c;
                        gnt_q    <= gnt_c;
                        rr_ptr_q <= ~gnt_c;
                    end
                end
                soc_pkg::XB_WAIT_RSP: begin
                    if (rsp_valid) begin
                        state_q <= soc_pkg::XB_IDLE;
                    end
                end
                default: state_q <= soc_pkg::XB_IDLE;
            endcase
        end
    end

endmodule

// ==== sram_slave.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module sram_slave (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  soc_pkg::bus_req_t req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output soc_pkg::bus_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(`SOC_SRAM_DEPTH);

    soc_pkg::data_t   mem [`SOC_SRAM_DEPTH];
    logic [IDX_W-1:0] idx;

    assign req_ready_o = 1'b1;
    assign idx         = req_i.addr[IDX_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

    // Writes answer with zero data.
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            if (req_i.we) begin
                mem[idx]    <= req_i.wdata;
                rsp_o.rdata <= '0;
            end else begin
                rsp_o.rdata <= mem[idx];
            end
            rsp_o.err <= 1'b0;
        end
    end

endmodule

// ==== sensor_ctrl.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module sensor_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  soc_pkg::bus_req_t req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output soc_pkg::bus_rsp_t rsp_o,
    input  logic              sensor_ready_i,
    input  soc_pkg::data_t    sensor_data_i,
    output logic              sensor_en_o,
    output logic              sensor_int_o
);

    localparam int IDX_W    = $clog2(`SOC_SENSOR_DEPTH);
    localparam int CNT_W    = IDX_W + 1;
    localparam int FULL_BIT = 8;

    soc_pkg::data_t   buffer [`SOC_SENSOR_DEPTH];
    logic [CNT_W-1:0] count_q;
    logic             enable_q;
    logic             int_q;
    logic             full;
    logic             sample;
    logic             ctrl_wr;
    soc_pkg::off_t    off;
    soc_pkg::data_t   rd_data;

    assign req_ready_o  = 1'b1;
    assign off          = req_i.addr[`SOC_REGION_LSB-1:0];
    assign full         = (count_q == CNT_W'(`SOC_SENSOR_DEPTH));
    assign ctrl_wr      = req_valid_i && req_i.we && (off == '0);
    assign sample       = enable_q && sensor_ready_i && !full && !ctrl_wr;
    assign sensor_en_o  = enable_q;
    assign sensor_int_o = int_q;

    // Last sample drops enable and raises the interrupt on the same edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable_q <= 1'b0;
            count_q  <= '0;
            int_q    <= 1'b0;
        end else if (ctrl_wr) begin
            enable_q <= req_i.wdata[0];
            count_q  <= '0;
            int_q    <= 1'b0;
        end else if (sample) begin
            count_q <= count_q + 1'b1;
            if (count_q == CNT_W'(`SOC_SENSOR_DEPTH - 1)) begin
                enable_q <= 1'b0;
                int_q    <= 1'b1;
            end
        end
    end

    // STATUS holds the count in the low bits and full in bit 8.
    always_comb begin
        rd_data = '0;
        if (off == soc_pkg::off_t'(0)) begin
            rd_data[0] = enable_q;
        end else if (off == soc_pkg::off_t'(1)) begin
            rd_data[CNT_W-1:0] = count_q;
            rd_data[FULL_BIT]  = full;
        end else if (off[`SOC_REGION_LSB-1:IDX_W] == 1) begin
            rd_data = buffer[off[IDX_W-1:0]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            buffer[count_q[IDX_W-1:0]] <= sensor_data_i;
        end
        if (req_valid_i) begin
            rsp_o.rdata <= req_i.we ? '0 : rd_data;
            rsp_o.err   <= 1'b0;
        end
    end

endmodule

// ==== dma_engine.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module dma_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              s_req_valid_i,
    input  soc_pkg::bus_req_t s_req_i,
    output logic              s_req_ready_o,
    output logic              s_rsp_valid_o,
    output soc_pkg::bus_rsp_t s_rsp_o,
    output logic              m_req_valid_o,
    output soc_pkg::bus_req_t m_req_o,
    input  logic              m_req_ready_i,
    input  logic              m_rsp_valid_i,
    input  soc_pkg::bus_rsp_t m_rsp_i,
    output logic              dma_int_o
);

    localparam soc_pkg::off_t OFF_SRC    = 0;
    localparam soc_pkg::off_t OFF_DST    = 1;
    localparam soc_pkg::off_t OFF_LEN    = 2;
    localparam soc_pkg::off_t OFF_CTRL   = 3;
    localparam soc_pkg::off_t OFF_STATUS = 4;

    soc_pkg::dma_state_e state_q;
    soc_pkg::addr_t      src_q;
    soc_pkg::addr_t      dst_q;
    soc_pkg::addr_t      len_q;
    soc_pkg::addr_t      cur_src_q;
    soc_pkg::addr_t      cur_dst_q;
    soc_pkg::addr_t      left_q;
    soc_pkg::data_t      data_q;
    soc_pkg::data_t      rd_data;
    soc_pkg::off_t       off;
    logic                done_q;
    logic                int_q;
    logic                busy;
    logic                reg_wr;
    logic                start;
    logic                int_clr;

    assign s_req_ready_o = 1'b1;
    assign off           = s_req_i.addr[`SOC_REGION_LSB-1:0];
    assign reg_wr        = s_req_valid_i && s_req_i.we;
    assign busy          = (state_q != soc_pkg::DMA_IDLE);
    assign start         = reg_wr && (off == OFF_CTRL) && s_req_i.wdata[0] && !busy;
    assign int_clr       = reg_wr && (off == OFF_CTRL) && s_req_i.wdata[1];
    assign dma_int_o     = int_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
        end else if (reg_wr) begin
            case (off)
                OFF_SRC: src_q <= s_req_i.wdata[`SOC_ADDR_W-1:0];
                OFF_DST: dst_q <= s_req_i.wdata[`SOC_ADDR_W-1:0];
                OFF_LEN: len_q <= s_req_i.wdata[`SOC_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        case (off)
            OFF_SRC:    rd_data[`SOC_ADDR_W-1:0] = src_q;
            OFF_DST:    rd_data[`SOC_ADDR_W-1:0] = dst_q;
            OFF_LEN:    rd_data[`SOC_ADDR_W-1:0] = len_q;
            OFF_STATUS: rd_data[1:0] = {done_q, busy};
            default:    ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_rsp_valid_o <= 1'b0;
        end else begin
            s_rsp_valid_o <= s_req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (s_req_valid_i) begin
            s_rsp_o.rdata <= s_req_i.we ? '0 : rd_data;
            s_rsp_o.err   <= 1'b0;
        end
    end

    // One word is a read followed by a write.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= soc_pkg::DMA_IDLE;
            left_q  <= '0;
            done_q  <= 1'b0;
            int_q   <= 1'b0;
        end else begin
            if (int_clr) begin
                int_q <= 1'b0;
            end
            case (state_q)
                soc_pkg::DMA_IDLE: begin
                    if (start) begin
                        left_q <= len_q;
                        if (len_q == '0) begin
                            done_q <= 1'b1;
                            int_q  <= 1'b1;
                        end else begin
                            done_q  <= 1'b0;
                            state_q <= soc_pkg::RD_REQ;
                        end
                    end
                end
                soc_pkg::RD_REQ: begin
                    if (m_req_ready_i) begin
                        state_q <= soc_pkg::RD_WAIT;
                    end
                end
                soc_pkg::RD_WAIT: begin
                    if (m_rsp_valid_i) begin
                        state_q <= soc_pkg::WR_REQ;
                    end
                end
                soc_pkg::WR_REQ: begin
                    if (m_req_ready_i) begin
                        state_q <= soc_pkg::WR_WAIT;
                    end
                end
                soc_pkg::WR_WAIT: begin
                    if (m_rsp_valid_i) begin
                        left_q <= left_q - 1'b1;
                        if (left_q == soc_pkg::addr_t'(1)) begin
                            state_q <= soc_pkg::DMA_IDLE;
                            done_q  <= 1'b1;
                            int_q   <= 1'b1;
                        end else begin
                            state_q <= soc_pkg::RD_REQ;
                        end
                    end
                end
                default: state_q <= soc_pkg::DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_src_q <= src_q;
            cur_dst_q <= dst_q;
        end
        if ((state_q == soc_pkg::RD_WAIT) && m_rsp_valid_i) begin
            data_q <= m_rsp_i.rdata;
        end
        if ((state_q == soc_pkg::WR_WAIT) && m_rsp_valid_i) begin
            cur_src_q <= cur_src_q + 1'b1;
            cur_dst_q <= cur_dst_q + 1'b1;
        end
    end

    assign m_req_valid_o = (state_q == soc_pkg::RD_REQ) || (state_q == soc_pkg::WR_REQ);
    assign m_req_o.addr  = (state_q == soc_pkg::WR_REQ) ? cur_dst_q : cur_src_q;
    assign m_req_o.wdata = data_q;
    assign m_req_o.we    = (state_q == soc_pkg::WR_REQ);

endmodule

// ==== soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_req_valid_i,
    input  soc_pkg::bus_req_t host_req_i,
    output logic              host_req_ready_o,
    output logic              host_rsp_valid_o,
    output soc_pkg::bus_rsp_t host_rsp_o,
    input  logic              sensor_ready_i,
    input  soc_pkg::data_t    sensor_data_i,
    output logic              sensor_en_o,
    output logic              sensor_int_o,
    output logic              dma_int_o
);

    logic              m_req_valid [2];
    soc_pkg::bus_req_t m_req       [2];
    logic              m_req_ready [2];
    logic              m_rsp_valid [2];
    soc_pkg::bus_rsp_t m_rsp       [2];
    logic              s_req_valid [3];
    soc_pkg::bus_req_t s_req       [3];
    logic              s_rsp_valid [3];
    soc_pkg::bus_rsp_t s_rsp       [3];

    // Master 0 is the host port, master 1 the DMA.
    assign m_req_valid[0]   = host_req_valid_i;
    assign m_req[0]         = host_req_i;
    assign host_req_ready_o = m_req_ready[0];
    assign host_rsp_valid_o = m_rsp_valid[0];
    assign host_rsp_o       = m_rsp[0];

    bus_xbar u_xbar (
        .clk           (clk        ),
        .rst           (rst        ),
        .m_req_valid_i (m_req_valid),
        .m_req_i       (m_req      ),
        .m_req_ready_o (m_req_ready),
        .m_rsp_valid_o (m_rsp_valid),
        .m_rsp_o       (m_rsp      ),
        .s_req_valid_o (s_req_valid),
        .s_req_o       (s_req      ),
        .s_rsp_valid_i (s_rsp_valid),
        .s_rsp_i       (s_rsp      )
    );

    sram_slave u_sram (
        .clk         (clk           ),
        .rst         (rst           ),
        .req_valid_i (s_req_valid[0]),
        .req_i       (s_req[0]      ),
        .req_ready_o (              ),
        .rsp_valid_o (s_rsp_valid[0]),
        .rsp_o       (s_rsp[0]      )
    );

    sensor_ctrl u_sensor (
        .clk            (clk           ),
        .rst            (rst           ),
        .req_valid_i    (s_req_valid[1]),
        .req_i          (s_req[1]      ),
        .req_ready_o    (              ),
        .rsp_valid_o    (s_rsp_valid[1]),
        .rsp_o          (s_rsp[1]      ),
        .sensor_ready_i (sensor_ready_i),
        .sensor_data_i  (sensor_data_i ),
        .sensor_en_o    (sensor_en_o   ),
        .sensor_int_o   (sensor_int_o  )
    );

    dma_engine u_dma (
        .clk           (clk           ),
        .rst           (rst           ),
        .s_req_valid_i (s_req_valid[2]),
        .s_req_i       (s_req[2]      ),
        .s_req_ready_o (              ),
        .s_rsp_valid_o (s_rsp_valid[2]),
        .s_rsp_o       (s_rsp[2]      ),
        .m_req_valid_o (m_req_valid[1]),
        .m_req_o       (m_req[1]      ),
        .m_req_ready_i (m_req_ready[1]),
        .m_rsp_valid_i (m_rsp_valid[1]),
        .m_rsp_i       (m_rsp[1]      ),
        .dma_int_o     (dma_int_o     )
    );

endmodule

// ==== soc_checker.sv ====
`timescale 1ns/10ps

module soc_checker (
    input logic              clk,
    input logic              rst,
    input logic              host_req_valid_i,
    input soc_pkg::bus_req_t host_req_i,
    input logic              host_req_ready_o,
    input logic              host_rsp_valid_o,
    input logic              sensor_en_o,
    input logic              sensor_int_o,
    input logic              dma_int_o
);

    logic outstanding_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (host_req_valid_i && host_req_ready_o) begin
            outstanding_q <= 1'b1;
        end else if (host_rsp_valid_o) begin
            outstanding_q <= 1'b0;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        host_req_valid_i && !host_req_ready_o |=> host_req_valid_i && $stable(host_req_i))
        else $error("host request changed while waiting for ready");

    a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
        host_rsp_valid_o |-> outstanding_q)
        else $error("host response without an accepted request");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !sensor_int_o && !dma_int_o && !sensor_en_o)
        else $error("interrupt or sensor enable high during reset");

endmodule

bind soc_top soc_checker u_checker (
    .clk              (clk             ),
    .rst              (rst             ),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i      ),
    .host_req_ready_o (host_req_ready_o),
    .host_rsp_valid_o (host_rsp_valid_o),
    .sensor_en_o      (sensor_en_o     ),
    .sensor_int_o     (sensor_int_o    ),
    .dma_int_o        (dma_int_o       )
);

// ==== soc_monitor.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module soc_monitor (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_req_valid_i,
    input  soc_pkg::bus_req_t host_req_i,
    input  logic              host_req_ready_o,
    input  logic              host_rsp_valid_o,
    input  soc_pkg::bus_rsp_t host_rsp_o,
    input  logic              sensor_ready_i,
    input  soc_pkg::data_t    sensor_data_i,
    input  logic              sensor_en_o,
    input  logic              sensor_int_o,
    input  logic              dma_int_o,
    output int                errors_o,
    output int                checks_o
);

    soc_pkg::data_t    sram_m  [`SOC_SRAM_DEPTH];
    soc_pkg::data_t    samples [`SOC_SENSOR_DEPTH];
    int                sample_cnt;
    logic              sens_en;
    logic              sens_int;
    soc_pkg::addr_t    dma_src;
    soc_pkg::addr_t    dma_dst;
    soc_pkg::addr_t    dma_len;
    logic              dma_busy;
    logic              dma_done;
    logic              dma_int_m;
    logic              pending;
    logic              timed;
    int                wait_cnt;
    soc_pkg::bus_rsp_t exp_rsp;
    logic              ctrl_wr;
    logic              accepted;

    initial begin
        errors_o = 0;
        checks_o = 0;
        pending  = 1'b0;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks_o++;
        if (exp !== act) begin
            errors_o++;
            $display("error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Expected response from the model state before the edge.
    function automatic soc_pkg::bus_rsp_t expect_rsp(input soc_pkg::bus_req_t req);
        soc_pkg::bus_rsp_t r;
        soc_pkg::off_t     off;
        r   = '0;
        off = req.addr[`SOC_REGION_LSB-1:0];
        case (req.addr[11:10])
            2'd0: if (!req.we) r.rdata = sram_m[req.addr[7:0]];
            2'd1: begin
                if (!req.we && off == 0) r.rdata = {31'd0, sens_en};
                if (!req.we && off == 1) r.rdata = sample_cnt | ((sample_cnt == 16) << 8);
                if (!req.we && off >= 16 && off < 32) r.rdata = samples[off - 16];
            end
            2'd2: begin
                if (!req.we && off == 0) r.rdata = 32'(dma_src);
                if (!req.we && off == 1) r.rdata = 32'(dma_dst);
                if (!req.we && off == 2) r.rdata = 32'(dma_len);
                if (!req.we && off == 4) r.rdata = {30'd0, dma_done, dma_busy};
            end
            default: r.err = 1'b1;
        endcase
        return r;
    endfunction

    task automatic apply_write(input soc_pkg::bus_req_t req);
        soc_pkg::off_t off;
        off = req.addr[`SOC_REGION_LSB-1:0];
        case (req.addr[11:10])
            2'd0: sram_m[req.addr[7:0]] = req.wdata;
            2'd1: begin
                if (off == 0) begin
                    sens_en    = req.wdata[0];
                    sample_cnt = 0;
                    sens_int   = 1'b0;
                end
            end
            2'd2: begin
                if (off == 0) dma_src = req.wdata[11:0];
                if (off == 1) dma_dst = req.wdata[11:0];
                if (off == 2) dma_len = req.wdata[11:0];
                if (off == 3 && req.wdata[1]) dma_int_m = 1'b0;
                // The copy is modelled whole at the start command.
                if (off == 3 && req.wdata[0] && !dma_busy) begin
                    for (int i = 0; i < int'(dma_len); i++) begin
                        sram_m[8'(dma_dst + i)] = sram_m[8'(dma_src + i)];
                    end
                    dma_done  = (dma_len == 0);
                    dma_busy  = (dma_len != 0);
                    dma_int_m = dma_int_m | (dma_len == 0);
                end
            end
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        if (rst) begin
            sample_cnt = 0;
            sens_en    = 1'b0;
            sens_int   = 1'b0;
            dma_src    = '0;
            dma_dst    = '0;
            dma_len    = '0;
            dma_busy   = 1'b0;
            dma_done   = 1'b0;
            dma_int_m  = 1'b0;
            pending    = 1'b0;
        end else begin
            accepted = host_req_valid_i && host_req_ready_o;
            ctrl_wr  = accepted && host_req_i.we && (host_req_i.addr == 12'h400);
            if (host_rsp_valid_o) begin
                if (!pending) begin
                    errors_o++;
                    $display("Host response arrived with no request outstanding at %0t", $time);
                end else begin
                    check("host_rsp_o.rdata", exp_rsp.rdata, host_rsp_o.rdata);
                    check("host_rsp_o.err", 32'(exp_rsp.err), 32'(host_rsp_o.err));
                    if (timed) check("host_rsp_latency", 1, wait_cnt);
                end
                pending = 1'b0;
            end else if (pending) begin
                wait_cnt++;
            end
            if (dma_busy && dma_int_o) begin
                dma_busy  = 1'b0;
                dma_done  = 1'b1;
                dma_int_m = 1'b1;
            end
            if (accepted) begin
                exp_rsp  = expect_rsp(host_req_i);
                pending  = 1'b1;
                wait_cnt = 1;
                timed    = !dma_busy;
            end
            if (sens_en && sensor_ready_i && !ctrl_wr && sample_cnt < 16) begin
                samples[sample_cnt] = sensor_data_i;
                sample_cnt++;
                if (sample_cnt == 16) begin
                    sens_en  = 1'b0;
                    sens_int = 1'b1;
                end
            end
            if (accepted && host_req_i.we) apply_write(host_req_i);
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            check("host_req_ready_o", 0, 32'(host_req_ready_o));
            check("host_rsp_valid_o", 0, 32'(host_rsp_valid_o));
            check("sensor_en_o", 0, 32'(sensor_en_o));
            check("sensor_int_o", 0, 32'(sensor_int_o));
            check("dma_int_o", 0, 32'(dma_int_o));
        end else begin
            check("sensor_en_o", 32'(sens_en), 32'(sensor_en_o));
            check("sensor_int_o", 32'(sens_int), 32'(sensor_int_o));
            if (!dma_busy) check("dma_int_o", 32'(dma_int_m), 32'(dma_int_o));
        end
    end

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/10ps

module tb_soc;

    localparam int N_TXN      = 450;
    localparam int CLK_PERIOD = 8;
    localparam logic [11:0] SENS_CTRL   = 12'h400;
    localparam logic [11:0] SENS_STATUS = 12'h401;
    localparam logic [11:0] DMA_BASE    = 12'h800;

    logic              clk = 1'b0;
    logic              rst;
    logic              host_req_valid;
    soc_pkg::bus_req_t host_req;
    logic              host_req_ready;
    logic              host_rsp_valid;
    soc_pkg::bus_rsp_t host_rsp;
    logic              sensor_ready;
    soc_pkg::data_t    sensor_data;
    logic              sensor_en;
    logic              sensor_int;
    logic              dma_int;
    int                errors;
    int                checks;
    logic [11:0]       addrs [32];

    always #(CLK_PERIOD / 2) clk = ~clk;

    soc_top u_dut (
        .clk              (clk           ),
        .rst              (rst           ),
        .host_req_valid_i (host_req_valid),
        .host_req_i       (host_req      ),
        .host_req_ready_o (host_req_ready),
        .host_rsp_valid_o (host_rsp_valid),
        .host_rsp_o       (host_rsp      ),
        .sensor_ready_i   (sensor_ready  ),
        .sensor_data_i    (sensor_data   ),
        .sensor_en_o      (sensor_en     ),
        .sensor_int_o     (sensor_int    ),
        .dma_int_o        (dma_int       )
    );

    soc_monitor u_mon (
        .clk              (clk           ),
        .rst              (rst           ),
        .host_req_valid_i (host_req_valid),
        .host_req_i       (host_req      ),
        .host_req_ready_o (host_req_ready),
        .host_rsp_valid_o (host_rsp_valid),
        .host_rsp_o       (host_rsp      ),
        .sensor_ready_i   (sensor_ready  ),
        .sensor_data_i    (sensor_data   ),
        .sensor_en_o      (sensor_en     ),
        .sensor_int_o     (sensor_int    ),
        .dma_int_o        (dma_int       ),
        .errors_o         (errors        ),
        .checks_o         (checks        )
    );

    // Sensor model offers a random word about every other cycle.
    always @(posedge clk) begin
        if (!rst) begin
            sensor_ready <= 1'($urandom);
            sensor_data  <= $urandom;
        end
    end

    // One request at a time; returns after its response.
    task automatic access(input logic [11:0] addr, input logic [31:0] wdata, input logic we);
        @(posedge clk);
        host_req_valid <= 1'b1;
        host_req       <= '{addr: addr, wdata: wdata, we: we};
        do @(posedge clk); while (!host_req_ready);
        host_req_valid <= 1'b0;
        do @(posedge clk); while (!host_rsp_valid);
    endtask

    task automatic run_dma(input logic with_host);
        logic [11:0] src;
        logic [11:0] dst;
        logic [11:0] len;
        src = 12'($urandom % 112);
        dst = 12'(128 + $urandom % 96);
        len = 12'(1 + $urandom % 16);
        access(DMA_BASE, 32'(src), 1'b1);
        access(DMA_BASE + 1, 32'(dst), 1'b1);
        access(DMA_BASE + 2, 32'(len), 1'b1);
        access(DMA_BASE + 3, 32'h1, 1'b1);
        // Addresses 240 and up lie outside both copy ranges.
        if (with_host) begin
            for (int i = 0; i < 12; i++) begin
                access(12'(240 + $urandom % 16), $urandom, 1'($urandom));
            end
        end
        while (!dma_int) @(posedge clk);
        access(DMA_BASE + 4, '0, 1'b0);
        for (int i = 0; i < int'(len); i++) access(dst + 12'(i), '0, 1'b0);
        access(DMA_BASE + 3, 32'h2, 1'b1);
    endtask

    initial begin
        void'($urandom(58));
        rst            = 1'b1;
        host_req_valid = 1'b0;
        host_req       = '0;
        sensor_ready   = 1'b0;
        sensor_data    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int a = 0; a < 256; a++) access(12'(a), $urandom, 1'b1);
        for (int i = 0; i < 32; i++) begin
            addrs[i] = 12'($urandom % 256);
            access(addrs[i], $urandom, 1'b1);
        end
        for (int i = 0; i < 32; i++) access(addrs[$urandom % 32], '0, 1'b0);

        for (int i = 0; i < 8; i++) begin
            addrs[i] = 12'hC00 | 12'($urandom % 1024);
            access(addrs[i], $urandom, 1'(i));
        end
        // SRAM words that share the low address bits keep their data.
        for (int i = 0; i < 8; i++) access(addrs[i] & 12'h0FF, '0, 1'b0);

        access(SENS_CTRL, 32'h1, 1'b1);
        while (!sensor_int) @(posedge clk);
        access(SENS_STATUS, '0, 1'b0);
        for (int i = 0; i < 16; i++) access(12'h410 + 12'(i), '0, 1'b0);
        access(SENS_CTRL, 32'h0, 1'b1);
        access(SENS_STATUS, '0, 1'b0);

        run_dma(1'b0);
        run_dma(1'b1);
        repeat (2) @(posedge clk);

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((N_TXN * 50 + 1000) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
soc_pkg.sv
bus_xbar.sv
sram_slave.sv
sensor_ctrl.sv
dma_engine.sv
soc_top.sv
soc_checker.sv
soc_monitor.sv
tb_soc.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_soc
FILELIST = project.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
